/* rtl/accum_settings.svh */
/*
  bus widths and register map size of the sequence accumulator
  include in any file that sizes a port or selects a register word
*/
`ifndef ACCUM_SETTINGS_SVH
`define ACCUM_SETTINGS_SVH

// axi data bus and register word width
`define ACC_DATA_WIDTH 32

// byte address into the register window
`define ACC_ADDR_WIDTH 7

// first address bit above the byte lanes
`define ACC_WORD_LSB 2

// words 0 to 3 host side, 4 to 7 engine side
`define ACC_NUM_REGS 8

`endif

/* rtl/accum_pkg.sv */
/*
  types and register index names shared by the accumulator blocks
  referenced by scoped names, compiled before any module
*/
`default_nettype none

`include "accum_settings.svh"

package accum_pkg;

  localparam int count_w = 16;

  typedef logic [`ACC_DATA_WIDTH-1:0] word_t;
  typedef logic [`ACC_ADDR_WIDTH-1:0] axi_addr_t;
  // term count lives in the low half of the count word
  typedef logic [count_w-1:0] count_t;

  // host written words
  localparam int reg_ctrl   = 0;
  localparam int reg_count  = 1;
  localparam int reg_base   = 2;
  localparam int reg_stride = 3;
  // engine written words
  localparam int reg_status = 4;
  localparam int reg_result = 5;
  localparam int reg_runs   = 6;
  localparam int reg_wraps  = 7;

  typedef enum logic {
    st_idle,
    st_run
  } engine_state_t;

endpackage

`default_nettype wire

/* rtl/engine_if.sv */
/*
  level signals between the register bank and the accumulation engine
  regs side drives the operands, engine side drives status and results
*/
`timescale 1ns/10ps
`default_nettype none

interface engine_if;

  // host to engine
  logic               start;
  accum_pkg::count_t  count;
  accum_pkg::word_t   base;
  accum_pkg::word_t   stride;

  // engine to host
  logic               busy;
  logic               done;
  accum_pkg::word_t   result;
  accum_pkg::word_t   runs;
  accum_pkg::word_t   wraps;

  modport regs (
    output start, count, base, stride,
    input  busy, done, result, runs, wraps
  );

  modport engine (
    input  start, count, base, stride,
    output busy, done, result, runs, wraps
  );

endinterface

`default_nettype wire

/* rtl/axi_lite_regs.sv */
/*
  axi4-lite slave holding the eight accumulator register words
  one write and one read in flight, fixed latency, always OKAY
*/
`timescale 1ns/10ps
`default_nettype none

`include "accum_settings.svh"

module axi_lite_regs (
  input  wire                          clk,
  input  wire                          xrst,
  input  accum_pkg::axi_addr_t         awaddr,
  input  wire  [2:0]                   awprot,
  input  wire                          awvalid,
  output logic                         awready,
  input  accum_pkg::word_t             wdata,
  input  wire  [`ACC_DATA_WIDTH/8-1:0] wstrb,
  input  wire                          wvalid,
  output logic                         wready,
  output logic                         bvalid,
  input  wire                          bready,
  output logic [1:0]                   bresp,
  input  accum_pkg::axi_addr_t         araddr,
  input  wire  [2:0]                   arprot,
  input  wire                          arvalid,
  output logic                         arready,
  output logic                         rvalid,
  input  wire                          rready,
  output accum_pkg::word_t             rdata,
  output logic [1:0]                   rresp,
  engine_if.regs                       eng
);

  localparam int strb_w    = `ACC_DATA_WIDTH / 8;
  localparam int idx_w     = `ACC_ADDR_WIDTH - `ACC_WORD_LSB;
  localparam int reg_idx_w = $clog2(`ACC_NUM_REGS);
  localparam logic [1:0] resp_okay = 2'b00;

  accum_pkg::word_t     regs [`ACC_NUM_REGS];
  accum_pkg::axi_addr_t wr_addr;
  accum_pkg::axi_addr_t rd_addr;
  logic [idx_w-1:0]     wr_idx;
  logic [idx_w-1:0]     rd_idx;
  logic                 wr_take;
  logic                 wr_en;
  logic                 rd_take;
  logic                 rd_en;

  // first sight of a new transfer, only while no response waits
  assign wr_take = !awready && awvalid && wvalid && !bvalid;
  assign wr_en   = awready && awvalid && wready && wvalid;
  assign rd_take = !arready && arvalid && !rvalid;
  assign rd_en   = arready && arvalid;

  assign wr_idx = wr_addr[`ACC_ADDR_WIDTH-1:`ACC_WORD_LSB];
  assign rd_idx = rd_addr[`ACC_ADDR_WIDTH-1:`ACC_WORD_LSB];

  assign bresp = resp_okay;
  assign rresp = resp_okay;

  // ====================
  // write channel
  // ====================

  // ready pulses for one cycle, address and data together
  always_ff @(posedge clk) begin
    if (!xrst) begin
      awready <= 1'b0;
      wready  <= 1'b0;
    end else begin
      awready <= wr_take;
      wready  <= wr_take;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_take) begin
      wr_addr <= awaddr;
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      bvalid <= 1'b0;
    end else if (wr_en) begin
      bvalid <= 1'b1;
    end else if (bready) begin
      bvalid <= 1'b0;
    end
  end

  // ====================
  // read channel
  // ====================

  always_ff @(posedge clk) begin
    if (!xrst) begin
      arready <= 1'b0;
    end else begin
      arready <= rd_take;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_take) begin
      rd_addr <= araddr;
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      rvalid <= 1'b0;
    end else if (rd_en) begin
      rvalid <= 1'b1;
    end else if (rready) begin
      rvalid <= 1'b0;
    end
  end

  // unmapped words read as zero
  always_ff @(posedge clk) begin
    if (rd_en) begin
      if (rd_idx < `ACC_NUM_REGS) begin
        rdata <= regs[rd_idx[reg_idx_w-1:0]];
      end else begin
        rdata <= '0;
      end
    end
  end

  // ====================
  // register array
  // ====================

  always_ff @(posedge clk) begin
    if (!xrst) begin
      for (int i = 0; i < `ACC_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      if (wr_idx < `ACC_NUM_REGS) begin
        for (int b = 0; b < strb_w; b++) begin
          if (wstrb[b]) begin
            regs[wr_idx[reg_idx_w-1:0]][b*8 +: 8] <= wdata[b*8 +: 8];
          end
        end
      end
    end else begin
      // engine side words follow the engine when the bus is quiet
      regs[accum_pkg::reg_status] <= {{(`ACC_DATA_WIDTH-2){1'b0}}, eng.done, eng.busy};
      regs[accum_pkg::reg_result] <= eng.result;
      regs[accum_pkg::reg_runs]   <= eng.runs;
      regs[accum_pkg::reg_wraps]  <= eng.wraps;
    end
  end

  assign eng.start  = regs[accum_pkg::reg_ctrl][0];
  assign eng.count  = regs[accum_pkg::reg_count][accum_pkg::count_w-1:0];
  assign eng.base   = regs[accum_pkg::reg_base];
  assign eng.stride = regs[accum_pkg::reg_stride];

  // ====================
  // handshake checks
  // ====================

  a_bvalid_hold: assert property (@(posedge clk) disable iff (!xrst)
    bvalid && !bready |=> bvalid);

  a_rvalid_hold: assert property (@(posedge clk) disable iff (!xrst)
    rvalid && !rready |=> rvalid && $stable(rdata));

  // ready only answers a pair of valids already seen
  a_wready_valids: assert property (@(posedge clk) disable iff (!xrst)
    (awready || wready) |-> awvalid && wvalid);

  // host keeps a pending request steady, prot included
  a_aw_steady: assert property (@(posedge clk) disable iff (!xrst)
    awvalid && !awready |=> awvalid && $stable({awaddr, awprot}));

  a_ar_steady: assert property (@(posedge clk) disable iff (!xrst)
    arvalid && !arready |=> arvalid && $stable({araddr, arprot}));

endmodule

`default_nettype wire

/* rtl/seq_accum.sv */
/*
  arithmetic sequence accumulator started by a rising start level
  sums count terms of base + k*stride, counts carries out of the msb
*/
`timescale 1ns/10ps
`default_nettype none

module seq_accum (
  input  wire     clk,
  input  wire     xrst,
  engine_if.engine eng
);

  accum_pkg::engine_state_t           state;
  logic                               start_q;
  logic                               start_rise;
  logic                               done;
  accum_pkg::count_t                  remaining;
  accum_pkg::word_t                   term;
  accum_pkg::word_t                   stride_q;
  accum_pkg::word_t                   acc;
  accum_pkg::word_t                   runs;
  accum_pkg::word_t                   wraps;
  logic [$bits(accum_pkg::word_t):0]  sum_next;

  // start edge only counts while idle
  assign start_rise = eng.start && !start_q;

  // top bit is the carry out of this term
  assign sum_next = {1'b0, acc} + {1'b0, term};

  // ====================
  // state and results
  // ====================

  always_ff @(posedge clk) begin
    if (!xrst) begin
      state   <= accum_pkg::st_idle;
      start_q <= 1'b0;
      done    <= 1'b0;
      acc     <= '0;
      runs    <= '0;
      wraps   <= '0;
    end else begin
      start_q <= eng.start;
      case (state)
        accum_pkg::st_idle: begin
          if (start_rise) begin
            acc <= '0;
            // empty run finishes on the start edge
            if (eng.count == '0) begin
              done <= 1'b1;
              runs <= runs + 1'b1;
            end else begin
              done  <= 1'b0;
              state <= accum_pkg::st_run;
            end
          end
        end
        accum_pkg::st_run: begin
          acc <= sum_next[$bits(accum_pkg::word_t)-1:0];
          if (sum_next[$bits(accum_pkg::word_t)]) begin
            wraps <= wraps + 1'b1;
          end
          if (remaining == accum_pkg::count_t'(1)) begin
            state <= accum_pkg::st_idle;
            done  <= 1'b1;
            runs  <= runs + 1'b1;
          end
        end
        default: state <= accum_pkg::st_idle;
      endcase
    end
  end

  // ====================
  // operand stepping
  // ====================

  always_ff @(posedge clk) begin
    if (state == accum_pkg::st_idle && start_rise) begin
      remaining <= eng.count;
      term      <= eng.base;
      stride_q  <= eng.stride;
    end else if (state == accum_pkg::st_run) begin
      remaining <= remaining - 1'b1;
      term      <= term + stride_q;
    end
  end

  assign eng.busy   = (state == accum_pkg::st_run);
  assign eng.done   = done;
  assign eng.result = acc;
  assign eng.runs   = runs;
  assign eng.wraps  = wraps;

  a_busy_done: assert property (@(posedge clk) disable iff (!xrst)
    !(eng.busy && eng.done));

endmodule

`default_nettype wire

/* rtl/accum_top.sv */
/*
  sequence accumulator top with a plain axi4-lite slave port
  register bank feeds the engine over the engine bundle
*/
`timescale 1ns/10ps
`default_nettype none

`include "accum_settings.svh"

module accum_top (
  input  wire                          clk,
  input  wire                          xrst,
  input  accum_pkg::axi_addr_t         awaddr,
  input  wire  [2:0]                   awprot,
  input  wire                          awvalid,
  output wire                          awready,
  input  accum_pkg::word_t             wdata,
  input  wire  [`ACC_DATA_WIDTH/8-1:0] wstrb,
  input  wire                          wvalid,
  output wire                          wready,
  output wire                          bvalid,
  input  wire                          bready,
  output wire  [1:0]                   bresp,
  input  accum_pkg::axi_addr_t         araddr,
  input  wire  [2:0]                   arprot,
  input  wire                          arvalid,
  output wire                          arready,
  output wire                          rvalid,
  input  wire                          rready,
  output accum_pkg::word_t             rdata,
  output wire  [1:0]                   rresp
);

  engine_if eng_bus ();

  axi_lite_regs u_regs (
    .clk     (clk),
    .xrst    (xrst),
    .awaddr  (awaddr),
    .awprot  (awprot),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .wvalid  (wvalid),
    .wready  (wready),
    .bvalid  (bvalid),
    .bready  (bready),
    .bresp   (bresp),
    .araddr  (araddr),
    .arprot  (arprot),
    .arvalid (arvalid),
    .arready (arready),
    .rvalid  (rvalid),
    .rready  (rready),
    .rdata   (rdata),
    .rresp   (rresp),
    .eng     (eng_bus.regs)
  );

  seq_accum u_engine (
    .clk  (clk),
    .xrst (xrst),
    .eng  (eng_bus.engine)
  );

endmodule

`default_nettype wire

/* test/tb_clock.sv */
/*
  free running clock for the accumulator testbench
  instantiate once in the testbench top, period set by parameter
*/
`timescale 1ns/10ps
`default_nettype none

module tb_clock #(
  parameter int period_ns = 20
) (
  output logic clk
);

  initial clk = 1'b0;

  always #(period_ns / 2) clk = ~clk;

endmodule

`default_nettype wire

/* test/tb_accum.sv */
/*
  testbench for the sequence accumulator over its axi4-lite port
  host tasks drive the bus, concurrent assertions compare with the model
*/
`timescale 1ns/10ps
`default_nettype none

`include "accum_settings.svh"

module tb_accum;

  localparam int clk_period = 20;
  localparam int num_runs   = 10;

  logic                         clk;
  logic                         xrst;
  accum_pkg::axi_addr_t         awaddr;
  logic [2:0]                   awprot;
  logic                         awvalid;
  logic                         awready;
  accum_pkg::word_t             wdata;
  logic [`ACC_DATA_WIDTH/8-1:0] wstrb;
  logic                         wvalid;
  logic                         wready;
  logic                         bvalid;
  logic                         bready;
  logic [1:0]                   bresp;
  accum_pkg::axi_addr_t         araddr;
  logic [2:0]                   arprot;
  logic                         arvalid;
  logic                         arready;
  logic                         rvalid;
  logic                         rready;
  accum_pkg::word_t             rdata;
  logic [1:0]                   rresp;

  // model state
  accum_pkg::word_t mdl [4];
  accum_pkg::word_t exp_rdata;
  logic             rd_check;
  accum_pkg::word_t exp_runs;
  accum_pkg::word_t exp_wraps;
  logic [31:0]      lfsr;
  int               errors;
  int               checks;

  tb_clock #(.period_ns(clk_period)) u_clock (.clk(clk));

  accum_top uut (
    .clk(clk), .xrst(xrst),
    .awaddr(awaddr), .awprot(awprot), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
    .bvalid(bvalid), .bready(bready), .bresp(bresp),
    .araddr(araddr), .arprot(arprot), .arvalid(arvalid), .arready(arready),
    .rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp)
  );

  // ====================
  // checks
  // ====================

  a_rdata: assert property (@(posedge clk) disable iff (!xrst)
    rvalid && rready && rd_check |-> rdata == exp_rdata)
    else begin
      errors++;
      $display("ERR %0t rdata exp %h got %h", $time, exp_rdata, $sampled(rdata));
    end

  a_rresp: assert property (@(posedge clk) disable iff (!xrst)
    rvalid && rready |-> rresp == 2'b00)
    else begin
      errors++;
      $display("ERR %0t rresp exp 0 got %0d", $time, $sampled(rresp));
    end

  a_bresp: assert property (@(posedge clk) disable iff (!xrst)
    bvalid && bready |-> bresp == 2'b00)
    else begin
      errors++;
      $display("ERR %0t bresp exp 0 got %0d", $time, $sampled(bresp));
    end

  // stalled responses stay put
  a_r_stall: assert property (@(posedge clk) disable iff (!xrst)
    rvalid && !rready |=> rvalid && $stable(rdata))
    else begin
      errors++;
      $display("read response changed while stalled at %0t", $time);
    end

  a_b_stall: assert property (@(posedge clk) disable iff (!xrst)
    bvalid && !bready |=> bvalid)
    else begin
      errors++;
      $display("write response dropped while stalled at %0t", $time);
    end

  // no new transfer accepted while a response waits
  a_single: assert property (@(posedge clk) disable iff (!xrst)
    !(rvalid && arready) && !(bvalid && (awready || wready)))
    else begin
      errors++;
      $display("slave accepted a transfer with a response pending at %0t", $time);
    end

  a_reset_quiet: assert property (@(posedge clk)
    $rose(xrst) |-> !(awready || wready || bvalid || arready || rvalid))
    else begin
      errors++;
      $display("bus outputs not low right after reset");
    end

  // galois lfsr, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hb4bcd35c) : (lfsr >> 1);
    end
    return v;
  endfunction

  // plain sum of the sequence terms, carries land in the upper half
  function automatic logic [63:0] seq_sum(input int n, input accum_pkg::word_t b,
                                          input accum_pkg::word_t s);
    logic [63:0]      tot;
    accum_pkg::word_t t;
    tot = '0;
    t = b;
    for (int k = 0; k < n; k++) begin
      tot = tot + t;
      t = t + s;
    end
    return tot;
  endfunction

  // ====================
  // host tasks
  // ====================

  // a stalled response gets the same request raised again behind it
  task automatic write_word(input int idx, input accum_pkg::word_t data,
                            input logic [3:0] strb, input int stall);
    int reps;
    reps    = (stall > 0) ? 2 : 1;
    awaddr  = accum_pkg::axi_addr_t'(idx << `ACC_WORD_LSB);
    wdata   = data;
    wstrb   = strb;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    for (int k = 0; k < reps; k++) begin
      do @(negedge clk); while (!(awready && wready));
      @(posedge clk);
      #1;
      awvalid = (k + 1 < reps);
      wvalid  = (k + 1 < reps);
      repeat (stall) begin
        @(posedge clk);
        #1;
      end
      bready = 1'b1;
      do @(negedge clk); while (!bvalid);
      @(posedge clk);
      #1;
      bready = 1'b0;
    end
    if (idx < 4) begin
      for (int b = 0; b < 4; b++) begin
        if (strb[b]) mdl[idx][b*8 +: 8] = data[b*8 +: 8];
      end
    end
  endtask

  task automatic read_word(input int idx, input logic check, input accum_pkg::word_t exp,
                           input int stall, output accum_pkg::word_t data);
    int reps;
    reps    = (stall > 0) ? 2 : 1;
    araddr  = accum_pkg::axi_addr_t'(idx << `ACC_WORD_LSB);
    arvalid = 1'b1;
    for (int k = 0; k < reps; k++) begin
      do @(negedge clk); while (!arready);
      @(posedge clk);
      #1;
      arvalid = (k + 1 < reps);
      repeat (stall) begin
        @(posedge clk);
        #1;
      end
      exp_rdata = exp;
      rd_check  = check;
      rready    = 1'b1;
      do @(negedge clk); while (!rvalid);
      data = rdata;
      @(posedge clk);
      #1;
      rready   = 1'b0;
      rd_check = 1'b0;
      if (check) checks++;
    end
  endtask

  // one start with optional restart while busy, then result readback
  task automatic run_once(input int n, input accum_pkg::word_t b,
                          input accum_pkg::word_t s, input logic restart);
    logic [63:0]      tot;
    accum_pkg::word_t st;
    write_word(accum_pkg::reg_count, accum_pkg::word_t'(n), 4'hf, rand_bits(2));
    write_word(accum_pkg::reg_base, b, 4'hf, rand_bits(2));
    write_word(accum_pkg::reg_stride, s, 4'hf, rand_bits(2));
    write_word(accum_pkg::reg_ctrl, 32'h0, 4'hf, rand_bits(2));
    write_word(accum_pkg::reg_ctrl, 32'h1, 4'hf, 0);
    if (restart) begin
      write_word(accum_pkg::reg_ctrl, 32'h0, 4'hf, 0);
      write_word(accum_pkg::reg_ctrl, 32'h1, 4'hf, 0);
    end
    tot = seq_sum(n, b, s);
    exp_runs  = exp_runs + 1;
    exp_wraps = exp_wraps + tot[63:32];
    do read_word(accum_pkg::reg_status, 1'b0, '0, 0, st); while (st[1:0] != 2'b10);
    read_word(accum_pkg::reg_status, 1'b1, 32'h2, rand_bits(3), st);
    read_word(accum_pkg::reg_result, 1'b1, tot[31:0], rand_bits(3), st);
    read_word(accum_pkg::reg_runs, 1'b1, exp_runs, rand_bits(3), st);
    read_word(accum_pkg::reg_wraps, 1'b1, exp_wraps, rand_bits(3), st);
  endtask

  // ====================
  // stimulus
  // ====================

  initial begin
    accum_pkg::word_t d;
    accum_pkg::word_t v;
    int               idx;
    int               n;
    logic [3:0]       strb;
    lfsr = 32'h144a9d9e;
    errors = 0;
    checks = 0;
    exp_rdata = '0;
    rd_check = 1'b0;
    exp_runs = '0;
    exp_wraps = '0;
    for (int i = 0; i < 4; i++) mdl[i] = '0;
    xrst = 1'b0;
    awaddr = '0;
    awprot = '0;
    awvalid = 1'b0;
    wdata = '0;
    wstrb = '0;
    wvalid = 1'b0;
    bready = 1'b0;
    araddr = '0;
    arprot = '0;
    arvalid = 1'b0;
    rready = 1'b0;
    repeat (5) @(posedge clk);
    #1;
    xrst = 1'b1;

    // every word reads zero after reset
    for (int i = 0; i < `ACC_NUM_REGS; i++) read_word(i, 1'b1, '0, rand_bits(2), v);

    // strobed writes to host words, start bit kept clear
    for (int i = 0; i < 12; i++) begin
      idx  = rand_bits(2);
      strb = rand_bits(4);
      d    = rand_bits(32);
      if (idx == accum_pkg::reg_ctrl) d[0] = 1'b0;
      write_word(idx, d, strb, rand_bits(3));
      read_word(idx, 1'b1, mdl[idx], rand_bits(3), v);
    end
    for (int i = 0; i < 4; i++) begin
      read_word(8 + (rand_bits(5) % 24), 1'b1, '0, rand_bits(3), v);
    end

    // engine runs, one empty and one restarted while busy
    for (int r = 0; r < num_runs; r++) begin
      n = rand_bits(6) % 41;
      if (r == 1) n = 0;
      if (r == 3) n = 30 + rand_bits(3);
      run_once(n, rand_bits(32), rand_bits(32), r == 3);
    end

    repeat (2) @(posedge clk);
    $display("%0d errors in %0d checked reads", errors, checks);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  // watchdog scaled by the number of engine runs
  initial begin
    #((num_runs * 60 + 2000) * clk_period);
    $display("watchdog expired before the tests completed");
    $display("Checks failed");
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
+incdir+rtl
rtl/accum_pkg.sv
rtl/engine_if.sv
rtl/axi_lite_regs.sv
rtl/seq_accum.sv
rtl/accum_top.sv
test/tb_clock.sv
test/tb_accum.sv
